/* logic/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction field widths.
`define INSTR_W     32
`define OP_W        6
`define REG_W       5
`define SHAMT_W     5
`define FUNCT_W     6
`define IMM_W       16
`define TARGET_W    26

// primary opcodes.
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// funct codes of the SPECIAL group.
`define F_SLL       6'b000000
`define F_SRL       6'b000010
`define F_SRA       6'b000011
`define F_SLLV      6'b000100
`define F_SRLV      6'b000110
`define F_SRAV      6'b000111
`define F_JR        6'b001000
`define F_JALR      6'b001001
`define F_SYSCALL   6'b001100
`define F_BREAK     6'b001101
`define F_ADD       6'b100000
`define F_ADDU      6'b100001
`define F_SUB       6'b100010
`define F_SUBU      6'b100011
`define F_AND       6'b100100
`define F_OR        6'b100101
`define F_XOR       6'b100110
`define F_NOR       6'b100111
`define F_SLT       6'b101010
`define F_SLTU      6'b101011

// rt codes of the REGIMM group.
`define B_BLTZ      5'b00000
`define B_BGEZ      5'b00001
`define B_BLTZAL    5'b10000
`define B_BGEZAL    5'b10001

// rs codes of the COP0 group, ERET is the CO form.
`define C_MFC0      5'b00000
`define C_MTC0      5'b00100
`define C_ERET      5'b10000

`define LINK_REG    5'd31

`endif

/* logic/decode_pkg.sv */
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

    typedef logic [`REG_W-1:0] reg_addr_t;

    typedef struct packed {
        logic [`OP_W-1:0]    op;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [`SHAMT_W-1:0] shamt;
        logic [`FUNCT_W-1:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [`OP_W-1:0]  op;
        reg_addr_t         rs;
        reg_addr_t         rt;
        logic [`IMM_W-1:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [`OP_W-1:0]     op;
        logic [`TARGET_W-1:0] target;
    } j_fields_t;

    // one word, three views of its fields.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI, ALU_PASSA, ALU_PASSB
    } alu_func_t;

    typedef enum logic {REGB, IMM} alu_src_t;

    typedef enum logic [1:0] {MSIZE1, MSIZE2, MSIZE4} msize_t;

    typedef enum logic [2:0] {T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ} branch_type_t;

    typedef struct packed {
        alu_func_t    alufunc;
        alu_src_t     alusrc;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        msize_t       msize;
        logic         memsext;
        logic         zeroext;
        logic         branch;
        branch_type_t branch_type;
        logic         jump;
        logic         jr;
        logic         is_link;
        logic         shamt_valid;
        logic         cp0toreg;
        logic         cp0write;
        logic         is_eret;
        logic         is_sys;
        logic         is_bp;
    } control_t;

    typedef struct packed {
        logic reserved_instr;
        logic syscall;
        logic trap;
    } exc_flags_t;

    typedef enum logic [1:0] {NONE, INSTR, ERET} cp0_type_t;

    typedef struct packed {
        logic       valid;
        cp0_type_t  ctype;
        exc_flags_t etype;
    } cp0_control_t;

    // common result of every decoder.
    typedef struct packed {
        control_t     ctl;
        reg_addr_t    srcrega;
        reg_addr_t    srcregb;
        reg_addr_t    destreg;
        cp0_control_t cp0_ctl;
    } decode_t;

endpackage

`default_nettype wire

/* logic/special_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module special_decoder (
    input  logic [5:0]          funct,
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  decode_pkg::reg_addr_t rd,
    output decode_pkg::decode_t   result
);
    import decode_pkg::*;

    alu_func_t alu_op;
    logic      reg_op;
    logic      shift_imm;

    // register alu group, everything else falls through to reg_op low.
    always_comb begin
        alu_op    = ALU_ADD;
        reg_op    = 1'b1;
        shift_imm = 1'b0;
        case (funct)
            `F_ADD:  alu_op = ALU_ADD;
            `F_ADDU: alu_op = ALU_ADDU;
            `F_SUB:  alu_op = ALU_SUB;
            `F_SUBU: alu_op = ALU_SUBU;
            `F_SLT:  alu_op = ALU_SLT;
            `F_SLTU: alu_op = ALU_SLTU;
            `F_AND:  alu_op = ALU_AND;
            `F_OR:   alu_op = ALU_OR;
            `F_XOR:  alu_op = ALU_XOR;
            `F_NOR:  alu_op = ALU_NOR;
            `F_SLLV: alu_op = ALU_SLL;
            `F_SRLV: alu_op = ALU_SRL;
            `F_SRAV: alu_op = ALU_SRA;
            `F_SLL: begin
                alu_op    = ALU_SLL;
                shift_imm = 1'b1;
            end
            `F_SRL: begin
                alu_op    = ALU_SRL;
                shift_imm = 1'b1;
            end
            `F_SRA: begin
                alu_op    = ALU_SRA;
                shift_imm = 1'b1;
            end
            default: reg_op = 1'b0;
        endcase
    end

    always_comb begin
        result = '0;
        if (reg_op) begin
            result.ctl.alufunc     = alu_op;
            result.ctl.alusrc      = REGB;
            result.ctl.regwrite    = 1'b1;
            result.ctl.shamt_valid = shift_imm;
            // shift count comes from shamt, so rs is not read.
            result.srcrega         = shift_imm ? '0 : rs;
            result.srcregb         = rt;
            result.destreg         = rd;
        end else begin
            case (funct)
                `F_JR: begin
                    result.ctl.jump = 1'b1;
                    result.ctl.jr   = 1'b1;
                    result.srcrega  = rs;
                end
                `F_JALR: begin
                    result.ctl.jump     = 1'b1;
                    result.ctl.jr       = 1'b1;
                    result.ctl.regwrite = 1'b1;
                    result.ctl.is_link  = 1'b1;
                    result.srcrega      = rs;
                    result.destreg      = rd;
                end
                `F_SYSCALL: begin
                    result.ctl.is_sys              = 1'b1;
                    result.cp0_ctl.valid           = 1'b1;
                    result.cp0_ctl.ctype           = INSTR;
                    result.cp0_ctl.etype.syscall   = 1'b1;
                end
                `F_BREAK: begin
                    result.ctl.is_bp               = 1'b1;
                    result.cp0_ctl.valid           = 1'b1;
                    result.cp0_ctl.ctype           = INSTR;
                    result.cp0_ctl.etype.trap      = 1'b1;
                end
                default: result.cp0_ctl.etype.reserved_instr = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/regimm_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module regimm_decoder (
    input  decode_pkg::reg_addr_t rs,
    input  logic [4:0]          rt_code,
    output decode_pkg::decode_t   result
);
    import decode_pkg::*;

    always_comb begin
        result = '0;
        case (rt_code)
            `B_BLTZ, `B_BGEZ, `B_BLTZAL, `B_BGEZAL: begin
                result.ctl.branch = 1'b1;
                result.srcrega    = rs;
                if (rt_code == `B_BGEZ || rt_code == `B_BGEZAL) begin
                    result.ctl.branch_type = T_BGEZ;
                end else begin
                    result.ctl.branch_type = T_BLTZ;
                end
                // AL forms save the return address in r31.
                if (rt_code == `B_BLTZAL || rt_code == `B_BGEZAL) begin
                    result.ctl.regwrite = 1'b1;
                    result.ctl.is_link  = 1'b1;
                    result.destreg      = `LINK_REG;
                end
            end
            default: result.cp0_ctl.etype.reserved_instr = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cop0_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module cop0_decoder (
    input  logic [4:0]          rs_code,
    input  decode_pkg::reg_addr_t rt,
    output decode_pkg::decode_t   result
);
    import decode_pkg::*;

    always_comb begin
        result = '0;
        case (rs_code)
            `C_MFC0: begin
                // cp0 read goes through port a of the alu.
                result.ctl.alufunc   = ALU_PASSA;
                result.ctl.regwrite  = 1'b1;
                result.ctl.cp0toreg  = 1'b1;
                result.destreg       = rt;
                result.cp0_ctl.ctype = INSTR;
            end
            `C_MTC0: begin
                result.ctl.alufunc   = ALU_PASSB;
                result.ctl.cp0write  = 1'b1;
                result.srcregb       = rt;
                result.cp0_ctl.valid = 1'b1;
                result.cp0_ctl.ctype = INSTR;
            end
            `C_ERET: begin
                result.ctl.is_eret   = 1'b1;
                result.cp0_ctl.valid = 1'b1;
                result.cp0_ctl.ctype = ERET;
            end
            default: result.cp0_ctl.etype.reserved_instr = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* logic/opcode_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module opcode_decoder (
    input  decode_pkg::instr_t  instr,
    input  logic                valid,
    output decode_pkg::decode_t result
);
    import decode_pkg::*;

    logic [`OP_W-1:0] op;
    reg_addr_t        rs;
    reg_addr_t        rt;
    decode_t          special_res;
    decode_t          regimm_res;
    decode_t          cop0_res;

    assign op = instr.j.op;
    assign rs = instr.i.rs;
    assign rt = instr.i.rt;

    special_decoder u_special (
        .funct  (instr.r.funct),
        .rs     (rs),
        .rt     (rt),
        .rd     (instr.r.rd),
        .result (special_res)
    );

    // the REGIMM code sits in the rt slot.
    regimm_decoder u_regimm (
        .rs      (rs),
        .rt_code (rt),
        .result  (regimm_res)
    );

    cop0_decoder u_cop0 (
        .rs_code (rs),
        .rt      (rt),
        .result  (cop0_res)
    );

    function automatic alu_func_t imm_alu(input logic [`OP_W-1:0] code);
        alu_func_t f;
        case (code)
            `OP_ADDIU: f = ALU_ADDU;
            `OP_SLTI:  f = ALU_SLT;
            `OP_SLTIU: f = ALU_SLTU;
            `OP_ANDI:  f = ALU_AND;
            `OP_ORI:   f = ALU_OR;
            `OP_XORI:  f = ALU_XOR;
            `OP_LUI:   f = ALU_LUI;
            default:   f = ALU_ADD;
        endcase
        return f;
    endfunction

    // width is in the low two opcode bits for both loads and stores.
    function automatic msize_t mem_size(input logic [`OP_W-1:0] code);
        msize_t s;
        case (code[1:0])
            2'b00:   s = MSIZE1;
            2'b01:   s = MSIZE2;
            default: s = MSIZE4;
        endcase
        return s;
    endfunction

    always_comb begin
        result = '0;
        if (valid) begin
            case (op)
                `OP_SPECIAL: result = special_res;
                `OP_REGIMM:  result = regimm_res;
                `OP_COP0:    result = cop0_res;
                `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                    result.ctl.alufunc  = imm_alu(op);
                    result.ctl.alusrc   = IMM;
                    result.ctl.regwrite = 1'b1;
                    result.ctl.zeroext  = (op == `OP_ANDI) || (op == `OP_ORI) ||
                                          (op == `OP_XORI);
                    result.srcrega      = (op == `OP_LUI) ? '0 : rs;
                    result.destreg      = rt;
                end
                `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                    result.ctl.alusrc   = IMM;
                    result.ctl.regwrite = 1'b1;
                    result.ctl.memtoreg = 1'b1;
                    result.ctl.msize    = mem_size(op);
                    result.ctl.memsext  = (op == `OP_LB) || (op == `OP_LH);
                    result.srcrega      = rs;
                    result.destreg      = rt;
                end
                `OP_SB, `OP_SH, `OP_SW: begin
                    result.ctl.alusrc   = IMM;
                    result.ctl.memwrite = 1'b1;
                    result.ctl.msize    = mem_size(op);
                    result.srcrega      = rs;
                    result.srcregb      = rt;
                end
                `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                    result.ctl.branch = 1'b1;
                    result.srcrega    = rs;
                    case (op)
                        `OP_BEQ:  result.ctl.branch_type = T_BEQ;
                        `OP_BNE:  result.ctl.branch_type = T_BNE;
                        `OP_BLEZ: result.ctl.branch_type = T_BLEZ;
                        default:  result.ctl.branch_type = T_BGTZ;
                    endcase
                    if (op == `OP_BEQ || op == `OP_BNE) begin
                        result.srcregb = rt;
                    end
                end
                `OP_J: result.ctl.jump = 1'b1;
                `OP_JAL: begin
                    result.ctl.jump     = 1'b1;
                    result.ctl.regwrite = 1'b1;
                    result.ctl.is_link  = 1'b1;
                    result.destreg      = `LINK_REG;
                end
                default: result.cp0_ctl.etype.reserved_instr = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  decode_pkg::instr_t       instr,
    output logic                     ctl_valid,
    output decode_pkg::control_t     ctl,
    output decode_pkg::reg_addr_t    srcrega,
    output decode_pkg::reg_addr_t    srcregb,
    output decode_pkg::reg_addr_t    destreg,
    output decode_pkg::cp0_control_t cp0_ctl
);
    import decode_pkg::*;

    decode_t dec_next;
    decode_t dec_q;
    logic    valid_q;

    opcode_decoder u_opcode (
        .instr  (instr),
        .valid  (valid),
        .result (dec_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            dec_q   <= dec_next;
            valid_q <= valid;
        end
    end

    assign ctl_valid = valid_q;
    assign ctl       = dec_q.ctl;
    assign srcrega   = dec_q.srcrega;
    assign srcregb   = dec_q.srcregb;
    assign destreg   = dec_q.destreg;
    assign cp0_ctl   = dec_q.cp0_ctl;

    // no encoding may both branch and jump.
    a_branch_jump: assert property (@(posedge clk) disable iff (reset)
        !(ctl.branch && ctl.jump));

    a_mem_reg: assert property (@(posedge clk) disable iff (reset)
        !(ctl.memwrite && ctl.regwrite));

    // an idle slot carries no control.
    a_idle_zero: assert property (@(posedge clk) disable iff (reset)
        !ctl_valid |-> (ctl == '0));

endmodule

`default_nettype wire

/* test/tb_instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module tb_instr_decoder;
    import decode_pkg::*;

    logic         clk;
    logic         reset;
    logic         valid;
    instr_t       instr;
    logic         ctl_valid;
    control_t     ctl;
    reg_addr_t    srcrega;
    reg_addr_t    srcregb;
    reg_addr_t    destreg;
    cp0_control_t cp0_ctl;

    int          errors;
    int          checks;
    int          timeouts;
    logic [31:0] lcg_state;

    instr_decoder uut (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .instr     (instr),
        .ctl_valid (ctl_valid),
        .ctl       (ctl),
        .srcrega   (srcrega),
        .srcregb   (srcregb),
        .destreg   (destreg),
        .cp0_ctl   (cp0_ctl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa, input logic [5:0] fn);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_now(input string name, input logic exp_valid, input decode_t exp);
        decode_t act;
        act.ctl     = ctl;
        act.srcrega = srcrega;
        act.srcregb = srcregb;
        act.destreg = destreg;
        act.cp0_ctl = cp0_ctl;
        checks++;
        if (ctl_valid !== exp_valid || act !== exp) begin
            errors++;
            $display("FAIL %s: expected valid %0b result %h, actual valid %0b result %h",
                     name, exp_valid, exp, ctl_valid, act);
        end
    endtask

    // drive at the falling edge, then look one edge later.
    task automatic run_word(input string name, input logic [31:0] word, input logic v,
                            input decode_t exp);
        int edges;
        @(negedge clk);
        instr = word;
        valid = v;
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (ctl_valid !== v && edges < 4);
        if (ctl_valid !== v) begin
            timeouts++;
            $display("timeout: ctl_valid did not reach %0b within 4 cycles in %s", v, name);
        end else if (edges != 1) begin
            errors++;
            $display("latency in %s was %0d cycles instead of 1", name, edges);
        end else begin
            check_now(name, v, exp);
        end
    endtask

    task automatic test_reset_idle();
        decode_t     zero;
        decode_t     e;
        logic [31:0] r;
        int          cyc;
        zero  = '0;
        r     = lcg_next();
        // a valid word during reset must not reach the outputs.
        reset = 1'b1;
        valid = 1'b1;
        instr = {`OP_J, r[25:0]};
        for (cyc = 0; cyc < 8; cyc++) begin
            @(posedge clk);
            #1;
            check_now("reset", 1'b0, zero);
        end
        @(negedge clk);
        reset = 1'b0;
        valid = 1'b0;
        @(posedge clk);
        #1;
        check_now("after reset", 1'b0, zero);
        run_word("idle random", lcg_next(), 1'b0, zero);
        r = lcg_next();
        e = '0;
        e.ctl.jump = 1'b1;
        run_word("j before idle", {`OP_J, r[25:0]}, 1'b1, e);
        run_word("idle after j", lcg_next(), 1'b0, zero);
    endtask

    task automatic test_reg_alu();
        logic [5:0]  fn [16];
        alu_func_t   af [16];
        decode_t     e;
        logic [31:0] r;
        logic        shift_imm;
        int          k;
        fn = '{`F_ADD, `F_ADDU, `F_SUB, `F_SUBU, `F_SLT, `F_SLTU, `F_AND, `F_OR,
               `F_XOR, `F_NOR, `F_SLLV, `F_SRLV, `F_SRAV, `F_SLL, `F_SRL, `F_SRA};
        af = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
               ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLL, ALU_SRL, ALU_SRA};
        for (k = 0; k < 16; k++) begin
            r         = lcg_next();
            shift_imm = (k >= 13);
            e = '0;
            e.ctl.alufunc     = af[k];
            e.ctl.alusrc      = REGB;
            e.ctl.regwrite    = 1'b1;
            e.ctl.shamt_valid = shift_imm;
            e.srcrega         = shift_imm ? 5'd0 : r[25:21];
            e.srcregb         = r[20:16];
            e.destreg         = r[15:11];
            run_word($sformatf("reg_alu funct %02h", fn[k]),
                     r_word(`OP_SPECIAL, r[25:21], r[20:16], r[15:11], r[10:6], fn[k]),
                     1'b1, e);
        end
    endtask

    task automatic test_imm_alu();
        logic [5:0]  op [8];
        alu_func_t   af [8];
        decode_t     e;
        logic [31:0] r;
        int          k;
        op = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
        af = '{ALU_ADD, ALU_ADDU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI};
        for (k = 0; k < 8; k++) begin
            r = lcg_next();
            e = '0;
            e.ctl.alufunc  = af[k];
            e.ctl.alusrc   = IMM;
            e.ctl.regwrite = 1'b1;
            e.ctl.zeroext  = (k >= 4 && k <= 6);
            // lui has no source register.
            e.srcrega      = (k == 7) ? 5'd0 : r[25:21];
            e.destreg      = r[20:16];
            run_word($sformatf("imm_alu op %02h", op[k]),
                     i_word(op[k], r[25:21], r[20:16], r[15:0]), 1'b1, e);
        end
    endtask

    task automatic test_load_store();
        logic [5:0]  op [8];
        msize_t      ms [8];
        decode_t     e;
        logic [31:0] r;
        int          k;
        op = '{`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};
        ms = '{MSIZE1, MSIZE2, MSIZE4, MSIZE1, MSIZE2, MSIZE1, MSIZE2, MSIZE4};
        for (k = 0; k < 8; k++) begin
            r = lcg_next();
            e = '0;
            e.ctl.alusrc = IMM;
            e.ctl.msize  = ms[k];
            e.srcrega    = r[25:21];
            if (k >= 5) begin
                e.ctl.memwrite = 1'b1;
                e.srcregb      = r[20:16];
            end else begin
                e.ctl.regwrite = 1'b1;
                e.ctl.memtoreg = 1'b1;
                e.ctl.memsext  = (k < 2);
                e.destreg      = r[20:16];
            end
            run_word($sformatf("mem op %02h", op[k]),
                     i_word(op[k], r[25:21], r[20:16], r[15:0]), 1'b1, e);
        end
    endtask

    task automatic test_branch_jump();
        logic [5:0]   op [4];
        logic [4:0]   code [4];
        branch_type_t bt [4];
        branch_type_t rbt [4];
        decode_t      e;
        logic [31:0]  r;
        int           k;
        op   = '{`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ};
        bt   = '{T_BEQ, T_BNE, T_BLEZ, T_BGTZ};
        code = '{`B_BLTZ, `B_BGEZ, `B_BLTZAL, `B_BGEZAL};
        rbt  = '{T_BLTZ, T_BGEZ, T_BLTZ, T_BGEZ};
        for (k = 0; k < 4; k++) begin
            r = lcg_next();
            e = '0;
            e.ctl.branch      = 1'b1;
            e.ctl.branch_type = bt[k];
            e.srcrega         = r[25:21];
            e.srcregb         = (k < 2) ? r[20:16] : 5'd0;
            run_word($sformatf("branch op %02h", op[k]),
                     i_word(op[k], r[25:21], r[20:16], r[15:0]), 1'b1, e);
        end
        for (k = 0; k < 4; k++) begin
            r = lcg_next();
            e = '0;
            e.ctl.branch      = 1'b1;
            e.ctl.branch_type = rbt[k];
            e.srcrega         = r[25:21];
            if (k >= 2) begin
                e.ctl.regwrite = 1'b1;
                e.ctl.is_link  = 1'b1;
                e.destreg      = 5'd31;
            end
            run_word($sformatf("regimm rt %02h", code[k]),
                     i_word(`OP_REGIMM, r[25:21], code[k], r[15:0]), 1'b1, e);
        end
        r = lcg_next();
        e = '0;
        e.ctl.jump = 1'b1;
        run_word("j", {`OP_J, r[25:0]}, 1'b1, e);
        e.ctl.regwrite = 1'b1;
        e.ctl.is_link  = 1'b1;
        e.destreg      = 5'd31;
        run_word("jal", {`OP_JAL, r[25:0]}, 1'b1, e);
        e = '0;
        e.ctl.jump = 1'b1;
        e.ctl.jr   = 1'b1;
        e.srcrega  = r[25:21];
        run_word("jr", r_word(`OP_SPECIAL, r[25:21], 5'd0, 5'd0, 5'd0, `F_JR), 1'b1, e);
        e.ctl.regwrite = 1'b1;
        e.ctl.is_link  = 1'b1;
        e.destreg      = r[15:11];
        run_word("jalr", r_word(`OP_SPECIAL, r[25:21], 5'd0, r[15:11], 5'd0, `F_JALR), 1'b1, e);
    endtask

    task automatic test_cop0_reserved();
        decode_t     e;
        decode_t     rsv;
        logic [31:0] r;
        r = lcg_next();
        e = '0;
        e.ctl.alufunc  = ALU_PASSA;
        e.ctl.regwrite = 1'b1;
        e.ctl.cp0toreg = 1'b1;
        e.destreg      = r[20:16];
        e.cp0_ctl.ctype = INSTR;
        run_word("mfc0", r_word(`OP_COP0, `C_MFC0, r[20:16], r[15:11], 5'd0, 6'd0), 1'b1, e);
        e = '0;
        e.ctl.alufunc   = ALU_PASSB;
        e.ctl.cp0write  = 1'b1;
        e.srcregb       = r[20:16];
        e.cp0_ctl.valid = 1'b1;
        e.cp0_ctl.ctype = INSTR;
        run_word("mtc0", r_word(`OP_COP0, `C_MTC0, r[20:16], r[15:11], 5'd0, 6'd0), 1'b1, e);
        e = '0;
        e.ctl.is_eret   = 1'b1;
        e.cp0_ctl.valid = 1'b1;
        e.cp0_ctl.ctype = ERET;
        run_word("eret", r_word(`OP_COP0, `C_ERET, 5'd0, 5'd0, 5'd0, 6'h18), 1'b1, e);
        // the code field of syscall and break is ignored.
        e = '0;
        e.ctl.is_sys = 1'b1;
        e.cp0_ctl.valid = 1'b1;
        e.cp0_ctl.ctype = INSTR;
        e.cp0_ctl.etype.syscall = 1'b1;
        run_word("syscall", {`OP_SPECIAL, r[25:6], `F_SYSCALL}, 1'b1, e);
        e = '0;
        e.ctl.is_bp = 1'b1;
        e.cp0_ctl.valid = 1'b1;
        e.cp0_ctl.ctype = INSTR;
        e.cp0_ctl.etype.trap = 1'b1;
        run_word("break", {`OP_SPECIAL, r[25:6], `F_BREAK}, 1'b1, e);
        rsv = '0;
        rsv.cp0_ctl.etype.reserved_instr = 1'b1;
        r = lcg_next();
        run_word("reserved opcode", {6'h3f, r[25:0]}, 1'b1, rsv);
        run_word("reserved funct",
                 r_word(`OP_SPECIAL, r[25:21], r[20:16], r[15:11], r[10:6], 6'h01), 1'b1, rsv);
        run_word("reserved regimm", i_word(`OP_REGIMM, r[25:21], 5'b00010, r[15:0]), 1'b1, rsv);
        run_word("reserved cop0",
                 r_word(`OP_COP0, 5'b00001, r[20:16], r[15:11], 5'd0, 6'd0), 1'b1, rsv);
    endtask

    initial begin
        reset     = 1'b1;
        valid     = 1'b0;
        instr     = '0;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        lcg_state = 32'h9ac6;
        test_reset_idle();
        test_reg_alu();
        test_imm_alu();
        test_load_store();
        test_branch_jump();
        test_cop0_reserved();
        $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* instr_decoder.f */
+incdir+logic
logic/decode_pkg.sv
logic/special_decoder.sv
logic/regimm_decoder.sv
logic/cop0_decoder.sv
logic/opcode_decoder.sv
logic/instr_decoder.sv
test/tb_instr_decoder.sv

/* Makefile */
TOP := tb_instr_decoder

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f instr_decoder.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
